// File: logic/loopPkg.sv
`default_nettype none

package loopPkg;

    // bus and datapath widths
    parameter int BUS_WIDTH = 32;   // data bus, accumulator and loopFreq
    parameter int EXP_WIDTH = 5;    // lead and lag gain exponents

    // register addresses on the microprocessor port
    parameter logic [11:0] LOOP_CTRL_ADDR  = 12'h000;
    parameter logic [11:0] LOOP_LIMIT_ADDR = 12'h004;

    // control register layout
    // lane 0 holds the single-bit flags, lanes 1 and 2 the exponents
    parameter int CTRL_INVERT_BIT = 0;  // negate the error
    parameter int CTRL_ZERO_BIT   = 1;  // force the error to zero
    parameter int CTRL_CTRL2_BIT  = 2;  // spare level to the outside
    parameter int CTRL_LEAD_LSB   = 8;  // lead exponent, bits 12:8
    parameter int CTRL_LAG_LSB    = 16; // lag exponent, bits 20:16

endpackage

`default_nettype wire

// File: logic/loopRegs.sv
`default_nettype none

module loopRegs (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 cs,
    input  wire                                 wr0,
    input  wire                                 wr1,
    input  wire                                 wr2,
    input  wire                                 wr3,
    input  wire  [11:0]                         addr,
    input  wire  [loopPkg::BUS_WIDTH-1:0]       din,
    output logic [loopPkg::BUS_WIDTH-1:0]       dout,
    output logic                                invertError,
    output logic                                zeroError,
    output logic                                ctrl2,
    output logic [loopPkg::EXP_WIDTH-1:0]       leadExp,
    output logic [loopPkg::EXP_WIDTH-1:0]       lagExp,
    output logic [loopPkg::BUS_WIDTH-1:0]       limit
);
    import loopPkg::*;

    logic [3:0]           laneWr;     // one strobe per byte lane
    logic                 anyWr;
    logic                 ctrlSel;
    logic                 limitSel;
    logic                 ctrlWe;
    logic                 limitWe;
    logic [BUS_WIDTH-1:0] ctrlWord;   // control register as seen on readback

    assign laneWr   = {wr3, wr2, wr1, wr0};
    assign anyWr    = |laneWr;
    assign ctrlSel  = cs && (addr == LOOP_CTRL_ADDR);
    assign limitSel = cs && (addr == LOOP_LIMIT_ADDR);
    assign ctrlWe   = ctrlSel && anyWr;
    assign limitWe  = limitSel && anyWr;

    // only the implemented control bits are stored
    // each field is written by the lane it sits in
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            invertError <= 1'b0;
            zeroError   <= 1'b0;
            ctrl2       <= 1'b0;
            leadExp     <= '0;
            lagExp      <= '0;
        end else if (ctrlWe) begin
            if (laneWr[CTRL_INVERT_BIT/8])
                invertError <= din[CTRL_INVERT_BIT];
            if (laneWr[CTRL_ZERO_BIT/8])
                zeroError <= din[CTRL_ZERO_BIT];
            if (laneWr[CTRL_CTRL2_BIT/8])
                ctrl2 <= din[CTRL_CTRL2_BIT];
            if (laneWr[CTRL_LEAD_LSB/8])
                leadExp <= din[CTRL_LEAD_LSB +: EXP_WIDTH];
            if (laneWr[CTRL_LAG_LSB/8])
                lagExp <= din[CTRL_LAG_LSB +: EXP_WIDTH];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            limit <= '0;
        end else if (limitWe) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneWr[lane])
                    limit[lane*8 +: 8] <= din[lane*8 +: 8];
            end
        end
    end

    always_comb begin
        ctrlWord                               = '0;   // unused bits read zero
        ctrlWord[CTRL_INVERT_BIT]              = invertError;
        ctrlWord[CTRL_ZERO_BIT]                = zeroError;
        ctrlWord[CTRL_CTRL2_BIT]               = ctrl2;
        ctrlWord[CTRL_LEAD_LSB +: EXP_WIDTH]   = leadExp;
        ctrlWord[CTRL_LAG_LSB +: EXP_WIDTH]    = lagExp;
    end

    // readback, zero when not selected
    always_comb begin
        if (ctrlSel)
            dout = ctrlWord;
        else if (limitSel)
            dout = limit;
        else
            dout = '0;
    end

    // the address map must keep the two registers apart
    writeOneReg: assert property (@(posedge clk) disable iff (reset)
        !($changed(ctrlWord) && $changed(limit)))
        else $error("loopRegs: control and limit written in the same cycle");

endmodule

`default_nettype wire

// File: logic/errorCondition.sv
`default_nettype none

module errorCondition #(
    parameter int ERROR_WIDTH = 8
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire  [ERROR_WIDTH-1:0] error,
    input  wire                    invertError,
    input  wire                    zeroError,
    output logic [ERROR_WIDTH-1:0] condError
);

    // sampled on every clock, the strobe is applied later in the gain stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            condError <= '0;
        end else if (zeroError) begin
            condError <= '0;              // zero wins over invert
        end else if (invertError) begin
            condError <= -error;          // most negative value wraps to itself
        end else begin
            condError <= error;
        end
    end

endmodule

`default_nettype wire

// File: logic/gainShift.sv
`default_nettype none

module gainShift #(
    parameter int ERROR_WIDTH = 8
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              filterEn,
    input  wire  [ERROR_WIDTH-1:0]           condError,
    input  wire  [loopPkg::EXP_WIDTH-1:0]    gainExp,
    output logic [loopPkg::BUS_WIDTH-1:0]    gainTerm
);
    import loopPkg::*;

    localparam int MAG_WIDTH  = ERROR_WIDTH - 1;
    localparam int FULL_WIDTH = 2*BUS_WIDTH + MAG_WIDTH;

    logic                   errSign;
    logic [MAG_WIDTH-1:0]   errMag;
    logic [FULL_WIDTH-1:0]  padded;   // magnitude framed by sign copies
    logic [BUS_WIDTH-2:0]   scaled;

    assign errSign = condError[ERROR_WIDTH-1];
    assign errMag  = condError[MAG_WIDTH-1:0];
    assign padded  = {{BUS_WIDTH{errSign}}, errMag, {BUS_WIDTH{errSign}}};

    // magnitude lsb lands at bit gainExp - MAG_WIDTH of the result
    // bits falling below zero drop out of the window
    always_comb begin
        scaled = padded[BUS_WIDTH + MAG_WIDTH - gainExp +: BUS_WIDTH-1];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gainTerm <= '0;
        end else if (filterEn) begin
            gainTerm <= {errSign, scaled};
        end
    end

    // sign fills every bit from the exponent upwards
    signKept: assert property (@(posedge clk) disable iff (reset)
        filterEn |=> ($signed(gainTerm) >>> $past(gainExp)) ==
                     $signed({BUS_WIDTH{$past(errSign)}}))
        else $error("gainShift: gain term sign differs from error sign");

endmodule

`default_nettype wire

// File: logic/lagIntegrator.sv
`default_nettype none

module lagIntegrator (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              filterEn,
    input  wire  [loopPkg::BUS_WIDTH-1:0]    lagTerm,
    input  wire  [loopPkg::BUS_WIDTH-1:0]    limit,
    output logic [loopPkg::BUS_WIDTH-1:0]    lagAccum
);
    import loopPkg::*;

    logic signed [BUS_WIDTH-1:0] sum;        // wraps, no carry out
    logic signed [BUS_WIDTH-1:0] upperLimit;
    logic signed [BUS_WIDTH-1:0] lowerLimit;
    logic        [BUS_WIDTH-1:0] clamped;

    assign sum        = lagAccum + lagTerm;
    assign upperLimit = limit;
    assign lowerLimit = -limit;

    // signed compare handles every sign mix of sum and limits
    always_comb begin
        if (sum >= upperLimit)
            clamped = upperLimit;
        else if (sum < lowerLimit)
            clamped = lowerLimit;
        else
            clamped = sum;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum <= '0;
        end else if (filterEn) begin
            lagAccum <= clamped;
        end
    end

    // limit used at the update still in place one clock later
    inLimits: assert property (@(posedge clk) disable iff (reset)
        filterEn ##1 $stable(limit) |->
            ($signed(lagAccum) <= upperLimit) && ($signed(lagAccum) >= lowerLimit))
        else $error("lagIntegrator: accumulator outside +/- limit");

endmodule

`default_nettype wire

// File: logic/loopFilter.sv
`default_nettype none

module loopFilter #(
    parameter int ERROR_WIDTH = 8
) (
    input  wire                              clk,
    input  wire                              clkEn,
    input  wire                              reset,
    input  wire                              cs,
    input  wire                              wr0,
    input  wire                              wr1,
    input  wire                              wr2,
    input  wire                              wr3,
    input  wire  [11:0]                      addr,
    input  wire  [loopPkg::BUS_WIDTH-1:0]    din,
    output logic [loopPkg::BUS_WIDTH-1:0]    dout,
    input  wire  [ERROR_WIDTH-1:0]           error,
    input  wire                              errorEn,
    output logic [loopPkg::BUS_WIDTH-1:0]    loopFreq,
    output logic                             ctrl2
);
    import loopPkg::*;

    logic                   filterEn;
    logic                   invertError;
    logic                   zeroError;
    logic [EXP_WIDTH-1:0]   leadExp;
    logic [EXP_WIDTH-1:0]   lagExp;
    logic [BUS_WIDTH-1:0]   limit;
    logic [ERROR_WIDTH-1:0] condError;
    logic [BUS_WIDTH-1:0]   leadTerm;
    logic [BUS_WIDTH-1:0]   lagTerm;
    logic [BUS_WIDTH-1:0]   lagAccum;

    assign filterEn = clkEn & errorEn;   // one enable for every stage

    loopRegs micro (
        .clk(clk), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .invertError(invertError), .zeroError(zeroError), .ctrl2(ctrl2),
        .leadExp(leadExp), .lagExp(lagExp), .limit(limit)
    );

    errorCondition #(.ERROR_WIDTH(ERROR_WIDTH)) adjust (
        .clk(clk), .reset(reset), .error(error),
        .invertError(invertError), .zeroError(zeroError),
        .condError(condError)
    );

    gainShift #(.ERROR_WIDTH(ERROR_WIDTH)) leadGain (
        .clk(clk), .reset(reset), .filterEn(filterEn),
        .condError(condError), .gainExp(leadExp), .gainTerm(leadTerm)
    );

    gainShift #(.ERROR_WIDTH(ERROR_WIDTH)) lagGain (
        .clk(clk), .reset(reset), .filterEn(filterEn),
        .condError(condError), .gainExp(lagExp), .gainTerm(lagTerm)
    );

    lagIntegrator integ (
        .clk(clk), .reset(reset), .filterEn(filterEn),
        .lagTerm(lagTerm), .limit(limit), .lagAccum(lagAccum)
    );

    // proportional plus integral, both as they stood before this strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loopFreq <= '0;
        end else if (filterEn) begin
            loopFreq <= lagAccum + leadTerm;   // to the NCO
        end
    end

endmodule

`default_nettype wire

// File: tests/loopFilterTb.sv
`default_nettype none

module loopFilterTb;
    import loopPkg::*;

    localparam int ERR_W          = 8;
    localparam int TIMEOUT_CYCLES = 3000;   // roughly twice the full sequence
    localparam logic [BUS_WIDTH-1:0] CTRL_MASK = (32'h1 << CTRL_INVERT_BIT)
        | (32'h1 << CTRL_ZERO_BIT) | (32'h1 << CTRL_CTRL2_BIT)
        | (32'h1F << CTRL_LEAD_LSB) | (32'h1F << CTRL_LAG_LSB);

    logic                 clk;
    logic                 clkEn;
    logic                 reset;
    logic                 cs;
    logic                 wr0, wr1, wr2, wr3;
    logic [11:0]          addr;
    logic [BUS_WIDTH-1:0] din;
    logic [BUS_WIDTH-1:0] dout;
    logic [ERR_W-1:0]     error;
    logic                 errorEn;
    logic [BUS_WIDTH-1:0] loopFreq;
    logic                 ctrl2;

    // shadow registers and reference datapath
    logic [BUS_WIDTH-1:0] shCtrl;
    logic [BUS_WIDTH-1:0] shLimit;
    logic [BUS_WIDTH-1:0] expDout;
    logic [ERR_W-1:0]     mCond;
    logic [BUS_WIDTH-1:0] mLead, mLag, mAccum, mFreq;
    logic                 hitHigh, hitLow;
    int                   cycles = 0;

    loopFilter #(.ERROR_WIDTH(ERR_W)) uut (
        .clk(clk), .clkEn(clkEn), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .error(error), .errorEn(errorEn), .loopFreq(loopFreq), .ctrl2(ctrl2)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
            abortRun("timeout: the test sequence did not finish in time");
    end

    // sign copied to bit 31 and above the magnitude, magnitude lsb at ex - (ERR_W-1)
    function automatic logic [BUS_WIDTH-1:0] gainOf(input logic [ERR_W-1:0] e,
                                                    input logic [EXP_WIDTH-1:0] ex);
        logic [BUS_WIDTH-1:0] r;
        int                   pos;
        int                   i;
        r = {BUS_WIDTH{e[ERR_W-1]}};
        for (i = 0; i < ERR_W-1; i++) begin
            pos = int'(ex) - (ERR_W-1) + i;
            if (pos >= 0)
                r[pos] = e[i];   // bits below zero are dropped
        end
        return r;
    endfunction

    function automatic logic [BUS_WIDTH-1:0] clampOf(input logic [BUS_WIDTH-1:0] acc,
                                                     input logic [BUS_WIDTH-1:0] term,
                                                     input logic [BUS_WIDTH-1:0] lim);
        logic signed [BUS_WIDTH-1:0] sum;
        logic signed [BUS_WIDTH-1:0] hi;
        logic signed [BUS_WIDTH-1:0] lo;
        sum = acc + term;
        hi  = lim;
        lo  = -lim;
        if (sum >= hi)
            return hi;
        else if (sum < lo)
            return lo;
        return sum;
    endfunction

    function automatic logic [ERR_W-1:0] conditionOf(input logic [ERR_W-1:0] e,
                                                     input logic inv, input logic zero);
        logic [ERR_W-1:0] r;
        r = e;
        if (zero)
            r = '0;
        else if (inv)
            r = ~e + 1'b1;   // two's complement, wraps for the minimum
        return r;
    endfunction

    // cycle model of the filter, clocked like the DUT
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            mCond  <= '0;
            mLead  <= '0;
            mLag   <= '0;
            mAccum <= '0;
            mFreq  <= '0;
        end else begin
            mCond <= conditionOf(error, shCtrl[CTRL_INVERT_BIT], shCtrl[CTRL_ZERO_BIT]);
            if (clkEn && errorEn) begin
                mLead  <= gainOf(mCond, shCtrl[CTRL_LEAD_LSB +: EXP_WIDTH]);
                mLag   <= gainOf(mCond, shCtrl[CTRL_LAG_LSB +: EXP_WIDTH]);
                mAccum <= clampOf(mAccum, mLag, shLimit);
                mFreq  <= mAccum + mLead;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && shLimit != '0) begin
            if (mAccum == shLimit)
                hitHigh <= 1'b1;
            if (mAccum == -shLimit)
                hitLow <= 1'b1;
        end
    end

    assign expDout = !cs ? '0 : (addr == LOOP_CTRL_ADDR) ? shCtrl :
                     (addr == LOOP_LIMIT_ADDR) ? shLimit : '0;

    freqMatch: assert property (@(posedge clk) disable iff (reset) loopFreq == mFreq)
        else abortRun($sformatf("FAIL loopFreq got %h expected %h",
                                $sampled(loopFreq), $sampled(mFreq)));
    accumMatch: assert property (@(posedge clk) disable iff (reset)
        uut.integ.lagAccum == mAccum)
        else abortRun($sformatf("FAIL lagAccum got %h expected %h",
                                $sampled(uut.integ.lagAccum), $sampled(mAccum)));
    doutMatch: assert property (@(posedge clk) disable iff (reset) dout == expDout)
        else abortRun($sformatf("FAIL dout got %h expected %h",
                                $sampled(dout), $sampled(expDout)));
    ctrl2Match: assert property (@(posedge clk) disable iff (reset)
        ctrl2 == shCtrl[CTRL_CTRL2_BIT])
        else abortRun($sformatf("FAIL ctrl2 got %h expected %h",
                                $sampled(ctrl2), $sampled(shCtrl[CTRL_CTRL2_BIT])));
    freqHeld: assert property (@(posedge clk) disable iff (reset)
        !(clkEn && errorEn) |=> $stable(loopFreq))
        else abortRun($sformatf("FAIL loopFreq moved without a strobe, now %h",
                                $sampled(loopFreq)));

    // shadow follows one half clock after the write edge, like the registers
    task automatic writeReg(input logic [11:0] a, input logic [BUS_WIDTH-1:0] d,
                            input logic [3:0] lanes);
        logic [BUS_WIDTH-1:0] merged;
        int                   lane;
        @(negedge clk);
        cs   = 1'b1;
        addr = a;
        din  = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(negedge clk);
        {wr3, wr2, wr1, wr0} = 4'b0000;
        cs     = 1'b0;
        merged = (a == LOOP_CTRL_ADDR) ? shCtrl : shLimit;
        for (lane = 0; lane < 4; lane++) begin
            if (lanes[lane])
                merged[lane*8 +: 8] = d[lane*8 +: 8];
        end
        if (a == LOOP_CTRL_ADDR)
            shCtrl = merged & CTRL_MASK;
        else if (a == LOOP_LIMIT_ADDR)
            shLimit = merged;
    endtask

    task automatic readReg(input logic [11:0] a);
        @(negedge clk);
        cs   = 1'b1;
        addr = a;
        @(negedge clk);
        cs = 1'b0;
    endtask

    // error held for the clock before and the clock of the strobe
    task automatic strobe(input logic [ERR_W-1:0] e);
        @(negedge clk);
        error   = e;
        errorEn = 1'b0;
        @(negedge clk);
        errorEn = 1'b1;
        @(negedge clk);
        errorEn = 1'b0;
    endtask

    task automatic strobeSet;
        strobe(8'h45);
        strobe(8'hB3);
        strobe(8'h7F);
        strobe(8'h80);
        strobe(8'h00);
    endtask

    task automatic leadRun(input logic [EXP_WIDTH-1:0] ex);
        writeReg(LOOP_CTRL_ADDR, BUS_WIDTH'(ex) << CTRL_LEAD_LSB, 4'hF);
        strobeSet();
    endtask

    // mode 1 keeps errors positive, mode 2 negative, mode 0 also toggles clkEn
    task automatic randomRun(input int count, input int mode);
        int n;
        for (n = 0; n < count; n++) begin
            @(negedge clk);
            error = ERR_W'($urandom);
            if (mode == 1)
                error[ERR_W-1] = 1'b0;
            else if (mode == 2)
                error[ERR_W-1] = 1'b1;
            errorEn = ($urandom % 4) != 0;
            clkEn   = (mode != 0) || (($urandom % 4) != 0);
        end
        @(negedge clk);
        errorEn = 1'b0;
        clkEn   = 1'b1;
    endtask

    task automatic gatingRun(input logic en, input logic clkOn);
        int n;
        for (n = 0; n < 20; n++) begin
            @(negedge clk);
            error   = ERR_W'($urandom);
            errorEn = en;
            clkEn   = clkOn;
        end
        @(negedge clk);
        errorEn = 1'b0;
        clkEn   = 1'b1;
    endtask

    initial begin
        void'($urandom(8));
        clkEn   = 1'b0;
        reset   = 1'b1;
        cs      = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr    = '0;
        din     = '0;
        error   = '0;
        errorEn = 1'b0;
        shCtrl  = '0;
        shLimit = '0;
        hitHigh = 1'b0;
        hitLow  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        clkEn = 1'b1;

        readReg(LOOP_CTRL_ADDR);   // everything zero out of reset
        readReg(LOOP_LIMIT_ADDR);

        writeReg(LOOP_CTRL_ADDR, 32'hFFFF_FFFF, 4'hF);
        readReg(LOOP_CTRL_ADDR);
        writeReg(LOOP_CTRL_ADDR, 32'h0000_0000, 4'b0010);
        readReg(LOOP_CTRL_ADDR);
        writeReg(LOOP_CTRL_ADDR, 32'h0000_0000, 4'b0001);
        writeReg(LOOP_CTRL_ADDR, 32'hFFFF_FF04, 4'b0001);   // ctrl2 alone
        readReg(LOOP_CTRL_ADDR);
        writeReg(LOOP_CTRL_ADDR, 32'h0000_0000, 4'hF);
        writeReg(LOOP_LIMIT_ADDR, 32'h1234_5678, 4'hF);
        writeReg(LOOP_LIMIT_ADDR, 32'hAABB_CCDD, 4'b0100);
        readReg(LOOP_LIMIT_ADDR);
        writeReg(LOOP_LIMIT_ADDR, 32'hEE00_0099, 4'b1001);
        readReg(LOOP_LIMIT_ADDR);
        readReg(12'h008);                                    // unmapped
        writeReg(LOOP_LIMIT_ADDR, 32'h0000_0000, 4'hF);

        leadRun(5'd0);
        leadRun(5'd7);
        leadRun(5'd8);
        leadRun(5'd31);

        writeReg(LOOP_CTRL_ADDR, (32'd8 << CTRL_LEAD_LSB) | 32'h1, 4'hF);
        strobeSet();
        writeReg(LOOP_CTRL_ADDR, (32'd8 << CTRL_LEAD_LSB) | 32'h3, 4'hF);
        strobeSet();
        writeReg(LOOP_CTRL_ADDR, (32'd8 << CTRL_LEAD_LSB) | 32'h2, 4'hF);
        strobeSet();

        writeReg(LOOP_LIMIT_ADDR, 32'h0000_0400, 4'hF);
        writeReg(LOOP_CTRL_ADDR, (32'd10 << CTRL_LAG_LSB) | (32'd4 << CTRL_LEAD_LSB), 4'hF);
        randomRun(200, 1);
        randomRun(200, 2);
        randomRun(800, 0);
        assert (hitHigh && hitLow)
            else abortRun("lag accumulator did not reach both the upper and lower limit");

        gatingRun(1'b0, 1'b1);
        gatingRun(1'b1, 1'b0);
        repeat (3) @(negedge clk);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/loopPkg.sv
logic/loopRegs.sv
logic/errorCondition.sv
logic/gainShift.sv
logic/lagIntegrator.sv
logic/loopFilter.sv
tests/loopFilterTb.sv
